// File: Makefile
# build and run the blur testbench with Verilator
TOP := blur_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// File: all.f
+incdir+design
design/blur_pkg.sv
design/blur_cfg_regs.sv
design/line_window.sv
design/stream_framer.sv
design/box_sum.sv
design/blur_top.sv
sim/blur_asserts.sv
sim/blur_tb.sv

// File: design/blur_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "blur_settings.svh"

module blur_cfg_regs (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                cfg_write,
    input  wire logic                cfg_addr,
    input  wire logic [7:0]          cfg_data,
    input  wire logic                frame_start,
    input  wire logic                frame_done,
    output blur_pkg::blur_cfg_t      cfg,
    output logic [15:0]              frame_count
);

    // shadow copy written by the host at any time
    logic               shadow_en;
    blur_pkg::weight_t  shadow_wt;

    // address 0 is the enable bit, address 1 the weight
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shadow_en <= 1'b1;
            shadow_wt <= blur_pkg::weight_t'(`BLUR_WEIGHT_RST);
        end else if (cfg_write) begin
            if (cfg_addr) begin
                shadow_wt <= cfg_data;
            end else begin
                shadow_en <= cfg_data[0];
            end
        end
    end

    // active copy only moves on the first pixel of a frame
    // so a frame is processed with one setting throughout
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.enable <= 1'b1;
            cfg.weight <= blur_pkg::weight_t'(`BLUR_WEIGHT_RST);
        end else if (frame_start) begin
            cfg.enable <= shadow_en;
            cfg.weight <= shadow_wt;
        end
    end

    // one count per eop beat taken downstream
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_count <= '0;
        end else if (frame_done) begin
            frame_count <= frame_count + 16'd1;
        end
    end

endmodule

`default_nettype wire

// File: design/blur_pkg.sv
`default_nettype none

package blur_pkg;

    // one colour channel of an rgb444 pixel
    typedef logic [3:0] channel_t;

    // red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] pixel_t;

    // sum of 25 channels, at most 25 * 15 = 375
    typedef logic [8:0] wsum_t;

    // kernel weight in units of 1/128
    typedef logic [7:0] weight_t;

    // one beat of the packet stream
    typedef struct packed {
        logic   valid;
        logic   sop;
        logic   eop;
        pixel_t data;
    } stream_t;

    // active configuration seen by the datapath
    typedef struct packed {
        logic    enable;
        weight_t weight;
    } blur_cfg_t;

endpackage

`default_nettype wire

// File: design/blur_settings.svh
`ifndef BLUR_SETTINGS_SVH
`define BLUR_SETTINGS_SVH

// frame geometry, kept small so one simulation covers whole frames
// frame width in pixels
`define BLUR_IMG_W 10

// frame height in pixels
`define BLUR_IMG_H 6

// side of the square box kernel
`define BLUR_K 5

// fraction bits of the weight, divisor is 2**BLUR_FRAC = 128
`define BLUR_FRAC 7

// weight after reset
// 5/128 is close to 1/25
`define BLUR_WEIGHT_RST 5

`endif

// File: design/blur_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "blur_settings.svh"

module blur_top (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               valid_in,
    input  wire logic               sop_in,
    input  wire logic               eop_in,
    input  wire blur_pkg::pixel_t   data_in,
    input  wire logic               ready_in,
    output logic                    ready_out,
    input  wire logic               cfg_write,
    input  wire logic               cfg_addr,
    input  wire logic [7:0]         cfg_data,
    output logic [15:0]             frame_count,
    output logic                    valid_out,
    output logic                    sop_out,
    output logic                    eop_out,
    output blur_pkg::pixel_t        data_out
);

    localparam int COL_W = $clog2(`BLUR_IMG_W);
    localparam int ROW_W = $clog2(`BLUR_IMG_H);

    logic                                       pixel_accept;
    logic                                       frame_start;
    logic                                       frame_done;
    logic                                       accept_q;
    logic [ROW_W-1:0]                           row;
    logic [COL_W-1:0]                           col;
    blur_pkg::pixel_t [`BLUR_K*`BLUR_K-1:0]     window;
    blur_pkg::blur_cfg_t                        cfg;
    blur_pkg::stream_t                          frame;
    blur_pkg::stream_t                          out;

    // ready is a straight pass-through, the pipeline only moves with it
    assign ready_out    = ready_in;
    assign pixel_accept = valid_in & ready_out;

    // frame length comes from the size macros
    // eop_in only marks the last accepted pixel of a frame
    assign frame_start  = pixel_accept & sop_in;
    assign frame_done   = out.valid & out.eop & ready_in;

    blur_cfg_regs u_cfg (
        .clk, .rst_n, .cfg_write, .cfg_addr, .cfg_data,
        .frame_start, .frame_done, .cfg, .frame_count
    );

    line_window #(.COL_W(COL_W), .ROW_W(ROW_W)) u_window (
        .clk, .rst_n, .pixel_accept, .sop_in, .data_in,
        .window, .row, .col, .accept_q
    );

    stream_framer #(.COL_W(COL_W), .ROW_W(ROW_W)) u_framer (
        .clk, .rst_n, .accept_q, .row, .col, .ready_in, .cfg, .frame
    );

    box_sum u_sum (
        .clk, .rst_n, .ready_in, .window, .frame, .cfg, .out
    );

    assign valid_out = out.valid;
    assign sop_out   = out.sop;
    assign eop_out   = out.eop;
    assign data_out  = out.data;

endmodule

`default_nettype wire

// File: design/box_sum.sv
`timescale 1ns/1ps
`default_nettype none

`include "blur_settings.svh"

module box_sum (
    input  wire logic                                    clk,
    input  wire logic                                    rst_n,
    input  wire logic                                    ready_in,
    input  wire blur_pkg::pixel_t [`BLUR_K*`BLUR_K-1:0]  window,
    input  wire blur_pkg::stream_t                       frame,
    input  wire blur_pkg::blur_cfg_t                     cfg,
    output blur_pkg::stream_t                            out
);

    localparam int N      = `BLUR_K * `BLUR_K;
    localparam int CH_W   = $bits(blur_pkg::channel_t);
    localparam int PROD_W = $bits(blur_pkg::wsum_t) + $bits(blur_pkg::weight_t);

    // adder trees over the current window
    blur_pkg::wsum_t sum_r, sum_g, sum_b;

    // stage 1, control comes already registered from the framer
    blur_pkg::wsum_t     s1_r, s1_g, s1_b;
    blur_pkg::pixel_t    s1_pix;
    blur_pkg::blur_cfg_t s1_cfg;
    blur_pkg::stream_t   s1;

    // stage 2, weighted sums
    logic [PROD_W-1:0]   s2_r, s2_g, s2_b;
    logic                s2_en;
    blur_pkg::stream_t   s2;

    always_comb begin
        sum_r = '0;
        sum_g = '0;
        sum_b = '0;
        for (int i = 0; i < N; i++) begin
            sum_r = sum_r + blur_pkg::wsum_t'(window[i][11:8]);
            sum_g = sum_g + blur_pkg::wsum_t'(window[i][7:4]);
            sum_b = sum_b + blur_pkg::wsum_t'(window[i][3:0]);
        end
    end

    // newest window pixel is the bypass value
    // cfg rides along so a frame boundary in flight keeps its own setting
    always_ff @(posedge clk) begin
        if (ready_in) begin
            s1_r   <= sum_r;
            s1_g   <= sum_g;
            s1_b   <= sum_b;
            s1_pix <= window[0];
            s1_cfg <= cfg;
        end
    end

    assign s1 = '{valid: frame.valid, sop: frame.sop, eop: frame.eop, data: s1_pix};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2.valid <= 1'b0;
            s2.sop   <= 1'b0;
            s2.eop   <= 1'b0;
        end else if (ready_in) begin
            s2    <= s1;
            s2_r  <= PROD_W'(s1_r) * PROD_W'(s1_cfg.weight);
            s2_g  <= PROD_W'(s1_g) * PROD_W'(s1_cfg.weight);
            s2_b  <= PROD_W'(s1_b) * PROD_W'(s1_cfg.weight);
            s2_en <= s1_cfg.enable;
        end
    end

    // divide by 2**FRAC, floor, low four bits per channel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
            out.sop   <= 1'b0;
            out.eop   <= 1'b0;
        end else if (ready_in) begin
            out.valid <= s2.valid;
            out.sop   <= s2.sop;
            out.eop   <= s2.eop;
            out.data  <= s2_en ? {s2_r[`BLUR_FRAC +: CH_W],
                                  s2_g[`BLUR_FRAC +: CH_W],
                                  s2_b[`BLUR_FRAC +: CH_W]}
                               : s2.data;
        end
    end

endmodule

`default_nettype wire

// File: design/line_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "blur_settings.svh"

module line_window #(
    parameter int COL_W = $clog2(`BLUR_IMG_W),
    parameter int ROW_W = $clog2(`BLUR_IMG_H)
) (
    input  wire logic                                    clk,
    input  wire logic                                    rst_n,
    input  wire logic                                    pixel_accept,
    input  wire logic                                    sop_in,
    input  wire blur_pkg::pixel_t                        data_in,
    output blur_pkg::pixel_t [`BLUR_K*`BLUR_K-1:0]       window,
    output logic [ROW_W-1:0]                             row,
    output logic [COL_W-1:0]                             col,
    output logic                                         accept_q
);

    localparam int K     = `BLUR_K;
    localparam int LINES = `BLUR_K - 1;

    // one entry per column, line k holds the pixel k+1 rows above
    blur_pkg::pixel_t line_mem [LINES][`BLUR_IMG_W];

    // window rows, [k][0] is the newest pixel of row k above
    blur_pkg::pixel_t win [K][K];

    // position the incoming pixel will take
    logic [COL_W-1:0] col_next;
    logic [ROW_W-1:0] row_next;
    logic             last_col;

    // column of the incoming pixel doubles as line buffer address
    blur_pkg::pixel_t tap [K];

    assign last_col = (col == COL_W'(`BLUR_IMG_W - 1));

    always_comb begin
        if (sop_in) begin
            // frame restarts at the top left corner
            col_next = '0;
            row_next = '0;
        end else if (last_col) begin
            col_next = '0;
            row_next = row + ROW_W'(1);
        end else begin
            col_next = col + COL_W'(1);
            row_next = row;
        end
    end

    // vertical taps, same column in the rows above
    always_comb begin
        tap[0] = data_in;
        for (int k = 1; k < K; k++) begin
            tap[k] = line_mem[k-1][col_next];
        end
    end

    // line buffers form a cascade
    // each one forwards the pixel it held for this column
    always_ff @(posedge clk) begin
        if (pixel_accept) begin
            for (int k = 0; k < LINES; k++) begin
                line_mem[k][col_next] <= tap[k];
            end
        end
    end

    // horizontal shift inside each window row
    always_ff @(posedge clk) begin
        if (pixel_accept) begin
            for (int k = 0; k < K; k++) begin
                win[k][0] <= tap[k];
                for (int j = 1; j < K; j++) begin
                    win[k][j] <= win[k][j-1];
                end
            end
        end
    end

    // flatten, index 0 is the newest pixel
    always_comb begin
        for (int k = 0; k < K; k++) begin
            for (int j = 0; j < K; j++) begin
                window[k*K + j] = win[k][j];
            end
        end
    end

    // raster position of the newest pixel in the window
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row      <= '0;
            col      <= '0;
            accept_q <= 1'b0;
        end else begin
            accept_q <= pixel_accept;
            if (pixel_accept) begin
                row <= row_next;
                col <= col_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/stream_framer.sv
`timescale 1ns/1ps
`default_nettype none

`include "blur_settings.svh"

module stream_framer #(
    parameter int COL_W = $clog2(`BLUR_IMG_W),
    parameter int ROW_W = $clog2(`BLUR_IMG_H)
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   accept_q,
    input  wire logic [ROW_W-1:0]       row,
    input  wire logic [COL_W-1:0]       col,
    input  wire logic                   ready_in,
    input  wire blur_pkg::blur_cfg_t    cfg,
    output blur_pkg::stream_t           frame
);

    // first position whose 5x5 window is fully inside the frame
    localparam logic [ROW_W-1:0] ROW_FIRST = ROW_W'(`BLUR_K - 1);
    localparam logic [COL_W-1:0] COL_FIRST = COL_W'(`BLUR_K - 1);

    // bottom right corner, end of frame in both modes
    localparam logic [ROW_W-1:0] ROW_LAST  = ROW_W'(`BLUR_IMG_H - 1);
    localparam logic [COL_W-1:0] COL_LAST  = COL_W'(`BLUR_IMG_W - 1);

    // window changed but the pipeline was stalled
    logic pending;

    // window holds a pixel that has not yet been framed
    logic fresh;

    logic in_range;
    logic emit;
    logic is_first;
    logic is_last;

    assign fresh = accept_q | pending;

    // accept_q lasts one cycle, keep it until the next advance
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (ready_in) begin
            pending <= 1'b0;
        end else if (accept_q) begin
            pending <= 1'b1;
        end
    end

    assign in_range = (row >= ROW_FIRST) && (col >= COL_FIRST);
    assign is_last  = (row == ROW_LAST) && (col == COL_LAST);

    always_comb begin
        if (cfg.enable) begin
            // blur, only full windows produce a pixel
            emit     = fresh && in_range;
            is_first = (row == ROW_FIRST) && (col == COL_FIRST);
        end else begin
            // bypass, every pixel goes through
            emit     = fresh;
            is_first = (row == '0) && (col == '0);
        end
    end

    // registered to line up with the first summing stage
    // data is filled in by box_sum
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame <= '0;
        end else if (ready_in) begin
            frame.valid <= emit;
            frame.sop   <= emit && is_first;
            frame.eop   <= emit && is_last;
            frame.data  <= '0;
        end
    end

endmodule

`default_nettype wire

// File: sim/blur_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module blur_asserts (
    input wire logic             clk,
    input wire logic             rst_n,
    input wire logic             ready_in,
    input wire logic             valid_out,
    input wire logic             sop_out,
    input wire logic             eop_out,
    input wire blur_pkg::pixel_t data_out
);

    // a stalled beat stays put until downstream takes it
    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out && !ready_in |=> valid_out && $stable({sop_out, eop_out, data_out}))
        else $error("output beat changed while stalled");

    // packet marks only ride on a valid beat
    marks_need_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (sop_out || eop_out) |-> valid_out)
        else $error("sop or eop without valid_out");

    // reset empties the output register
    idle_after_reset: assert property (@(posedge clk) !rst_n |=> !valid_out)
        else $error("valid_out high after reset");

endmodule

bind blur_top blur_asserts u_asserts (
    .clk(clk), .rst_n(rst_n), .ready_in(ready_in), .valid_out(valid_out),
    .sop_out(sop_out), .eop_out(eop_out), .data_out(data_out)
);

`default_nettype wire

// File: sim/blur_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "blur_settings.svh"

module blur_tb;

    localparam int NPIX   = `BLUR_IMG_W * `BLUR_IMG_H;
    localparam int NWIN   = (`BLUR_IMG_W - `BLUR_K + 1) * (`BLUR_IMG_H - `BLUR_K + 1);
    localparam int FRAMES = 5;
    localparam int LIMIT  = 4 * FRAMES * NPIX + 200;

    logic             clk;
    logic             rst_n;
    logic             valid_in;
    logic             sop_in;
    logic             eop_in;
    blur_pkg::pixel_t data_in;
    logic             ready_in;
    logic             ready_out;
    logic             cfg_write;
    logic             cfg_addr;
    logic [7:0]       cfg_data;
    logic [15:0]      frame_count;
    logic             valid_out;
    logic             sop_out;
    logic             eop_out;
    blur_pkg::pixel_t data_out;

    // input pixels first, then packed red/green/blue window sums
    logic [35:0] tdata [0:NPIX+NWIN-1];

    // scoreboard entries are {sop, eop, pixel}
    logic [13:0] exp_q [$];
    string       exp_name [$];

    integer seed;
    int     cycles = 0;
    int     eops = 0;
    int     acc_cycle = 0;
    logic   probe = 1'b0;
    logic   lat_done = 1'b0;

    blur_top DUT (
        .clk, .rst_n, .valid_in, .sop_in, .eop_in, .data_in, .ready_in, .ready_out,
        .cfg_write, .cfg_addr, .cfg_data, .frame_count,
        .valid_out, .sop_out, .eop_out, .data_out
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("error %s: expected 0x%0h, actual 0x%0h",
                                name, expected, actual));
        end
    endtask

    // window sum times weight, divided by 128 and rounded down
    function automatic logic [3:0] scaled_channel(input logic [11:0] sum, input int weight);
        return 4'((int'(sum) * weight) / (1 << `BLUR_FRAC));
    endfunction

    task automatic expect_blur(input string name, input int weight);
        logic [35:0] sums;
        for (int k = 0; k < NWIN; k++) begin
            sums = tdata[NPIX + k];
            exp_q.push_back({k == 0, k == NWIN - 1, scaled_channel(sums[35:24], weight),
                             scaled_channel(sums[23:12], weight),
                             scaled_channel(sums[11:0], weight)});
            exp_name.push_back($sformatf("%s pixel %0d", name, k));
        end
    endtask

    task automatic expect_bypass(input string name);
        for (int k = 0; k < NPIX; k++) begin
            exp_q.push_back({k == 0, k == NPIX - 1, tdata[k][11:0]});
            exp_name.push_back($sformatf("%s pixel %0d", name, k));
        end
    endtask

    task automatic write_reg(input logic addr, input logic [7:0] value);
        @(negedge clk);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_data  = value;
        @(negedge clk);
        cfg_write = 1'b0;
    endtask

    // one frame in raster order, optionally with valid gaps and ready drops
    // write_at >= 0 writes a new weight while that pixel is offered
    task automatic send_frame(input logic jitter, input int write_at, input logic [7:0] weight);
        int i;
        i = 0;
        while (i < NPIX) begin
            @(negedge clk);
            cfg_write = (i == write_at);
            cfg_addr  = 1'b1;
            cfg_data  = weight;
            ready_in  = jitter ? (($random(seed) & 3) != 0) : 1'b1;
            valid_in  = jitter ? (($random(seed) & 3) != 0) : 1'b1;
            sop_in    = (i == 0);
            eop_in    = (i == NPIX - 1);
            data_in   = tdata[i][11:0];
            if (valid_in && ready_in) begin
                i++;
            end
        end
        @(negedge clk);
        valid_in  = 1'b0;
        sop_in    = 1'b0;
        eop_in    = 1'b0;
        ready_in  = 1'b1;
        cfg_write = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // inputs change on the falling edge, so everything here is settled
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > LIMIT) begin
            abort_run($sformatf("timeout: the run did not finish within %0d cycles", LIMIT));
        end else begin
            // upstream sees the downstream ready unchanged
            compare_values("ready_out", 32'(ready_in), 32'(ready_out));
            if (valid_out && ready_in) begin
                if (exp_q.size() == 0) begin
                    abort_run("an output pixel arrived that no test expected");
                end else begin
                    compare_values(exp_name.pop_front(), 32'(exp_q.pop_front()),
                                   32'({sop_out, eop_out, data_out}));
                    if (eop_out) begin
                        eops = eops + 1;
                    end
                end
            end
            // edge of the first accepted pixel and the edge that raised valid_out
            if (probe && valid_in && ready_in && sop_in) begin
                acc_cycle = cycles;
            end
            if (probe && valid_out && sop_out && !lat_done) begin
                compare_values("bypass latency", 32'd3, 32'(cycles - acc_cycle - 1));
                lat_done = 1'b1;
            end
        end
    end

    initial begin
        seed      = 32'h0d87_b4b3;
        rst_n     = 1'b0;
        valid_in  = 1'b0;
        sop_in    = 1'b0;
        eop_in    = 1'b0;
        data_in   = '0;
        ready_in  = 1'b1;
        cfg_write = 1'b0;
        cfg_addr  = 1'b0;
        cfg_data  = '0;
        $readmemh("sim/blur_testdata.hex", tdata);
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // blur at the reset weight
        expect_blur("blur_w5", 5);
        send_frame(1'b0, -1, 8'd0);
        // weight 4 written mid frame only shows up one frame later
        expect_blur("blur_w5_kept", 5);
        send_frame(1'b0, NPIX / 2, 8'd4);
        expect_blur("blur_w4", 4);
        send_frame(1'b0, -1, 8'd0);
        wait_drain();

        // bypass, also measures the pipeline delay
        write_reg(1'b0, 8'd0);
        expect_bypass("bypass");
        probe = 1'b1;
        send_frame(1'b0, -1, 8'd0);
        wait_drain();
        probe = 1'b0;
        compare_values("latency measured", 32'd1, 32'(lat_done));

        // blur again under random stalls and gaps
        write_reg(1'b0, 8'd1);
        write_reg(1'b1, 8'd5);
        expect_blur("blur_stalled", 5);
        send_frame(1'b1, -1, 8'd0);
        wait_drain();

        // quiet tail catches extra beats
        repeat (10) @(negedge clk);
        compare_values("frames taken", 32'(FRAMES), 32'(eops));
        compare_values("frame_count", 32'(FRAMES), 32'(frame_count));
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/blur_testdata.hex
// lines 1 to 6: input pixels, rgb444 in raster order, one image row per line
// lines 7 to 18: red, green, blue window sums, three hex digits each, in output order
0f0 1e1 2d0 3c1 4b0 5a1 690 781 870 961
1f2 2e3 3d2 4c3 5b2 6a3 792 883 972 a63
2f4 3e5 4d4 5c5 6b4 7a5 894 985 a74 b65
3f6 4e7 5d6 6c7 7b6 8a7 996 a87 b76 c67
4f8 5e9 6d8 7c9 8b8 9a9 a98 b89 c78 d69
5fa 6eb 7da 8cb 9ba aab b9a c8b d7a e6b
06414506e
07d12c073
09611306e
0af0fa073
0c80e106e
0e10c8073
07d1450a0
09612c0a5
0af1130a0
0c80fa0a5
0e10e10a0
0fa0c80a5
